// File: video_subsystem.f
+incdir+common
common/video_pkg.sv
rtl/video_timing.sv
video_palframe/video_palframe.sv
rtl/video_top.sv
verif/tb_clock.sv
verif/video_checker.sv
verif/tb_video.sv

// File: verif/video_patterns.txt
# M up_ena sync_ena | C border data6 | U addr6 data8 | E addr9 color6 palcolor6
# R rnd pixels palsel ink paper upix border count(dec); rnd=1 randomizes pixels
M 0 0
C 1 3f
E 001 3e 3f
C 2 12
E 002 33 12
C 5 2d
E 005 0d 2d
C 0 06
E 000 0f 06
R 0 1 0 0 0 0 2 3200
R 0 5 0 0 0 0 0 3200
R 1 0 0 0 0 0 1 3200
# Border resync on
M 0 1
R 0 2 0 0 0 0 5 37
R 0 2 0 0 0 0 1 50
R 0 2 0 0 0 0 2 23
R 0 2 0 0 0 0 0 61
R 0 2 0 0 0 0 5 45
R 0 2 0 0 0 0 1 70
R 0 2 0 0 0 0 2 13
R 0 2 0 0 0 0 0 3200
# Border resync off
M 0 0
R 0 1 0 0 0 0 5 29
R 0 1 0 0 0 0 2 41
R 0 1 0 0 0 0 0 17
R 0 1 0 0 0 0 1 3200
# Extended palette
U 13 a5
E 113 19 09
U 1d 7e
E 11d 1b 36
U 02 c8
E 102 3c 1c
M 1 0
R 0 0 1 3 5 1 2 3200
R 0 0 1 3 5 0 2 3200
M 0 0
R 0 2 0 0 0 0 5 400

// File: verif/tb_video.sv
`timescale 1ns/1ps
`include "video_settings.svh"

module tb_video
    import video_pkg::*;
();

    localparam int HT    = `VID_H_TOTAL;
    localparam int VT    = `VID_V_TOTAL;
    localparam int LIMIT = 2 * HT * VT;  // Two frames.

    logic       clk;
    logic       rst_n;
    pixel_t     pix;
    logic [3:0] border;
    logic       border_sync_ena;
    logic       up_ena;
    palwr_t     palwr;
    vid_color_t color;
    logic [5:0] palcolor;
    logic       hsync_start;
    logic       vsync;

    logic [5:0] exp_color;
    logic       exp_color_valid;
    logic [5:0] exp_rb;
    logic       exp_rb_valid;
    int         checks;
    int         color_errors;
    int         rb_errors;
    int         sync_errors;
    int         other_errors;

    logic [5:0] tbl_color [0:511];
    logic [5:0] tbl_rb [0:511];
    bit         tbl_valid [0:511];

    pixel_t     pix_cur;
    logic [3:0] border_cur;
    logic       up_ena_cur;
    logic       sync_ena_cur;
    logic [3:0] synced_model;
    bit         synced_known;
    bit         locked;
    bit         timed_out;
    int         h;
    int         v;
    logic       vsync_q;
    logic [5:0] col_q1;
    logic [5:0] col_q2;
    logic       colv_q1;
    logic       colv_q2;
    logic [5:0] rb_q1;
    logic       rbv_q1;
    int         seed;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    video_top i_video_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .pix             (pix),
        .border          (border),
        .border_sync_ena (border_sync_ena),
        .up_ena          (up_ena),
        .palwr           (palwr),
        .color           (color),
        .palcolor        (palcolor),
        .hsync_start     (hsync_start),
        .vsync           (vsync)
    );

    video_checker i_video_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .color           (color),
        .palcolor        (palcolor),
        .hsync_start     (hsync_start),
        .vsync           (vsync),
        .exp_color       (exp_color),
        .exp_color_valid (exp_color_valid),
        .exp_rb          (exp_rb),
        .exp_rb_valid    (exp_rb_valid),
        .checks          (checks),
        .color_errors    (color_errors),
        .rb_errors       (rb_errors),
        .sync_errors     (sync_errors)
    );

    function automatic bit in_window(input int hp, input int vp);
        return hp >= `VID_H_PIX_START && hp < `VID_H_PIX_END &&
               vp >= `VID_V_PIX_START && vp < `VID_V_PIX_END;
    endfunction

    function automatic bit in_blank(input int hp, input int vp);
        return (hp >= `VID_H_BLANK_START && hp < `VID_H_BLANK_END) ||
               (vp >= `VID_V_BLANK_START && vp < `VID_V_BLANK_END);
    endfunction

    // One clock: follow the raster, drive inputs, queue the expected results.
    task automatic tick(input bit rnd_pix, input palwr_t wr);
        bit         win;
        bit         blk;
        bit         known;
        bit         ok;
        logic [3:0] zx;
        logic [8:0] addr;
        logic [31:0] rnd_val;
        @(posedge clk);
        #1;
        if (locked)
        begin
            if (h == HT - 1)
            begin
                h = 0;
                v = (v == VT - 1) ? 0 : v + 1;
            end
            else
                h = h + 1;
        end
        else if (vsync === 1'b1 && vsync_q === 1'b0)
        begin
            locked = 1;
            h      = 0;
            v      = `VID_V_SYNC_START;
        end
        vsync_q = vsync;
        if (rnd_pix)
        begin
            rnd_val        = $random(seed);
            pix_cur.pixels = rnd_val[3:0];
        end
        pix             = pix_cur;
        border          = border_cur;
        palwr           = wr;
        up_ena          = up_ena_cur;
        border_sync_ena = sync_ena_cur;
        win    = in_window(h, v);
        blk    = in_blank(h, v);
        known  = 1;
        if (up_ena_cur)
        begin
            if (win)
                addr = {3'b100, pix_cur.up_palsel, ~pix_cur.up_pixel,
                        pix_cur.up_pixel ? pix_cur.up_ink : pix_cur.up_paper};
            else
                addr = {6'b100000, border_cur[2:0]};
        end
        else
        begin
            if (win)
                zx = pix_cur.pixels;
            else if (sync_ena_cur)
            begin
                zx    = synced_model;
                known = synced_known;
            end
            else
                zx = border_cur;
            addr = {5'd0, zx};
        end
        ok = locked && known && tbl_valid[addr];
        if (locked && h % `VID_BORDER_SYNC_PERIOD == 0)
        begin
            synced_model = border_cur;  // Latched at the strobe.
            synced_known = 1;
        end
        exp_color       = col_q2;
        exp_color_valid = colv_q2;
        col_q2          = col_q1;
        colv_q2         = colv_q1;
        col_q1          = blk ? 6'd0 : tbl_color[addr];
        colv_q1         = locked && (blk || ok);
        exp_rb          = rb_q1;
        exp_rb_valid    = rbv_q1;
        rb_q1           = tbl_rb[addr];
        rbv_q1          = ok;
    endtask

    task automatic classic_write(input logic [3:0] b, input logic [5:0] d);
        palwr_t w;
        int     cnt;
        int     nh;
        int     nv;
        w             = '0;
        w.atm_palwr   = 1'b1;
        w.atm_paldata = d;
        border_cur    = b;
        cnt           = 0;
        forever
        begin
            nh = (h == HT - 1) ? 0 : h + 1;
            nv = (h == HT - 1) ? ((v == VT - 1) ? 0 : v + 1) : v;
            if (locked && !in_window(nh, nv))
                break;
            tick(0, '0);
            cnt++;
            if (cnt > LIMIT)
            begin
                $display("Timeout waiting for the border area before a palette write");
                timed_out = 1;
                break;
            end
        end
        if (!timed_out)
            tick(0, w);
    endtask

    initial
    begin
        int     fd;
        int     cnt;
        int     n;
        int     a;
        int     b;
        int     c;
        int     d;
        int     e;
        int     f;
        int     g;
        int     k;
        byte    cmd;
        string  line;
        palwr_t w;
        seed            = 32'h5a9496fd;
        pix             = '0;
        border          = '0;
        border_sync_ena = 1'b0;
        up_ena          = 1'b0;
        palwr           = '0;
        pix_cur         = '0;
        border_cur      = '0;
        up_ena_cur      = 1'b0;
        sync_ena_cur    = 1'b0;
        exp_color       = '0;
        exp_color_valid = 1'b0;
        exp_rb          = '0;
        exp_rb_valid    = 1'b0;
        col_q1          = '0;
        col_q2          = '0;
        colv_q1         = 1'b0;
        colv_q2         = 1'b0;
        rb_q1           = '0;
        rbv_q1          = 1'b0;
        synced_model    = '0;
        synced_known    = 0;
        locked          = 0;
        timed_out       = 0;
        h               = 0;
        v               = 0;
        vsync_q         = 1'b0;
        other_errors    = 0;
        for (int i = 0; i < 512; i++)
            tbl_valid[i] = 0;
        cnt = 0;
        while (rst_n !== 1'b1 && !timed_out)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > LIMIT)
            begin
                $display("Timeout waiting for reset release");
                timed_out = 1;
            end
        end
        cnt = 0;
        while (!locked && !timed_out)
        begin
            tick(0, '0);
            cnt++;
            if (cnt > LIMIT)
            begin
                $display("Timeout waiting for the first vsync");
                timed_out = 1;
            end
        end
        fd = $fopen("verif/video_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the patterns file");
            other_errors++;
        end
        while (fd != 0 && !timed_out && !$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n == 0 || $sscanf(line, " %c", cmd) != 1)
                continue;
            case (cmd)
                "M":
                begin
                    void'($sscanf(line, " M %h %h", a, b));
                    up_ena_cur   = a[0];
                    sync_ena_cur = b[0];
                    tick(0, '0);
                end
                "C":
                begin
                    void'($sscanf(line, " C %h %h", a, b));
                    classic_write(a[3:0], b[5:0]);
                end
                "U":
                begin
                    void'($sscanf(line, " U %h %h", a, b));
                    w            = '0;
                    w.up_palwr   = 1'b1;
                    w.up_paladdr = a[5:0];
                    w.up_paldata = b[7:0];
                    tick(0, w);
                end
                "E":
                begin
                    void'($sscanf(line, " E %h %h %h", a, b, c));
                    tbl_color[a[8:0]] = b[5:0];
                    tbl_rb[a[8:0]]    = c[5:0];
                    tbl_valid[a[8:0]] = 1;
                end
                "R":
                begin
                    void'($sscanf(line, " R %h %h %h %h %h %h %h %d",
                                  a, b, c, d, e, f, g, k));
                    pix_cur.pixels    = b[3:0];
                    pix_cur.up_palsel = c[1:0];
                    pix_cur.up_ink    = d[2:0];
                    pix_cur.up_paper  = e[2:0];
                    pix_cur.up_pixel  = f[0];
                    border_cur        = g[3:0];
                    repeat (k) tick(a[0], '0);
                end
                "#":
                    ;
                default:
                begin
                    $display("Unknown pattern line: %s", line);
                    other_errors++;
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);
        repeat (3) tick(0, '0);
        @(negedge clk);
        if (timed_out)
            other_errors++;
        if (checks == 0)
        begin
            $display("No colour comparisons were made");
            other_errors++;
        end
        $display("Checks %0d, color errors %0d, palcolor errors %0d, sync errors %0d, other %0d",
                 checks, color_errors, rb_errors, sync_errors, other_errors);
        if (color_errors + rb_errors + sync_errors + other_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verif/video_checker.sv
`timescale 1ns/1ps
`include "video_settings.svh"

module video_checker
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  vid_color_t color,
    input  logic [5:0] palcolor,
    input  logic       hsync_start,
    input  logic       vsync,
    input  logic [5:0] exp_color,
    input  logic       exp_color_valid,
    input  logic [5:0] exp_rb,
    input  logic       exp_rb_valid,
    output int         checks,
    output int         color_errors,
    output int         rb_errors,
    output int         sync_errors
);

    localparam int FRAME = `VID_H_TOTAL * `VID_V_TOTAL;

    int   hs_gap;
    int   vs_gap;
    bit   hs_seen;
    bit   vs_seen;
    logic vsync_q;

    initial
    begin
        checks       = 0;
        color_errors = 0;
        rb_errors    = 0;
        sync_errors  = 0;
        hs_gap       = 0;
        vs_gap       = 0;
        hs_seen      = 0;
        vs_seen      = 0;
        vsync_q      = 1'b0;
    end

    // Sampled mid-cycle, away from the driving edge.
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            if (color !== 6'd0)
            begin
                color_errors++;
                $display("** Error at %0t: color expected 00 actual %h", $time, color);
            end
            hs_seen = 0;
            vs_seen = 0;
            vsync_q = 1'b0;
        end
        else
        begin
            hs_gap++;
            vs_gap++;
            if (hsync_start === 1'b1)
            begin
                if (hs_seen && hs_gap != `VID_H_TOTAL)
                begin
                    sync_errors++;
                    $display("** Error at %0t: hsync_start period expected %0d actual %0d",
                             $time, `VID_H_TOTAL, hs_gap);
                end
                hs_seen = 1;
                hs_gap  = 0;
            end
            if (vsync === 1'b1 && vsync_q === 1'b0)
            begin
                if (vs_seen && vs_gap != FRAME)
                begin
                    sync_errors++;
                    $display("** Error at %0t: vsync period expected %0d actual %0d",
                             $time, FRAME, vs_gap);
                end
                vs_seen = 1;
                vs_gap  = 0;
            end
            vsync_q = vsync;
            if (exp_color_valid)
            begin
                checks++;
                if (color !== exp_color)
                begin
                    color_errors++;
                    $display("** Error at %0t: color expected %h actual %h",
                             $time, exp_color, color);
                end
            end
            if (exp_rb_valid && palcolor !== exp_rb)
            begin
                rb_errors++;
                $display("** Error at %0t: palcolor expected %h actual %h",
                         $time, exp_rb, palcolor);
            end
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    initial
    begin
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: rtl/video_top.sv
`timescale 1ns/1ps
`include "video_settings.svh"

module video_top
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pixel_t     pix,
    input  logic [3:0] border,
    input  logic       border_sync_ena,
    input  logic       up_ena,
    input  palwr_t     palwr,
    output vid_color_t color,
    output logic [5:0] palcolor,
    output logic       hsync_start,
    output logic       vsync
);

    localparam int LAT = `VID_PAL_LATENCY;

    raster_t        raster;
    logic [LAT-1:0] blank_dly;
    logic           blank;

    video_timing i_video_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster)
    );

    // Blanking follows the palette read pipeline.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            blank_dly <= '0;
        end
        else
        begin
            blank_dly[0] <= raster.hblank | raster.vblank;
            for (int i = 1; i < LAT; i++)
                blank_dly[i] <= blank_dly[i-1];
        end
    end

    assign blank = blank_dly[LAT-1];

    video_palframe i_video_palframe (
        .clk             (clk),
        .rst_n           (rst_n),
        .raster          (raster),
        .blank           (blank),
        .pix             (pix),
        .border          (border),
        .border_sync_ena (border_sync_ena),
        .up_ena          (up_ena),
        .palwr           (palwr),
        .palcolor        (palcolor),
        .color           (color)
    );

    assign hsync_start = raster.hsync_start;
    assign vsync       = raster.vsync;

endmodule

// File: video_palframe/video_palframe.sv
`timescale 1ns/1ps

module video_palframe
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  raster_t    raster,
    input  logic       blank,           // Already aligned with palette_read.
    input  pixel_t     pix,
    input  logic [3:0] border,
    input  logic       border_sync_ena,
    input  logic       up_ena,
    input  palwr_t     palwr,
    output logic [5:0] palcolor,
    output vid_color_t color
);

    logic       in_window;
    logic [3:0] synced_border;
    logic [3:0] zx_color;
    logic [2:0] up_attr;
    logic [5:0] up_color;
    logic [8:0] rd_addr;
    logic       wr_en;
    logic [8:0] wr_addr;
    logic [7:0] wr_data;
    logic [7:0] palette [0:511];
    logic [7:0] palette_read;
    vid_color_t pal_color;

    assign in_window = raster.hpix & raster.vpix;

    // Border is only picked up on the resync strobe.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            synced_border <= '0;
        else if (raster.border_sync)
            synced_border <= border;
    end

    always_comb
    begin
        if (in_window)
            zx_color = pix.pixels;
        else if (border_sync_ena)
            zx_color = synced_border;
        else
            zx_color = border;
    end

    assign up_attr = pix.up_pixel ? pix.up_ink : pix.up_paper;

    always_comb
    begin
        if (in_window)
            up_color = {pix.up_palsel, ~pix.up_pixel, up_attr};
        else
            up_color = {3'd0, border[2:0]};
    end

    // Extended entries live in the upper half.
    assign rd_addr = up_ena ? {3'b100, up_color} : {5'd0, zx_color};

    // Classic write takes priority and targets the index on screen.
    assign wr_en   = palwr.atm_palwr | palwr.up_palwr;
    assign wr_addr = palwr.atm_palwr ? {5'd0, zx_color} : {3'b100, palwr.up_paladdr};

    always_comb
    begin
        if (palwr.atm_palwr)
            wr_data = {palwr.atm_paldata[3:2], 1'b0,
                       palwr.atm_paldata[5:4], 1'b0,
                       palwr.atm_paldata[1:0]};
        else
            wr_data = palwr.up_paldata;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            palette[wr_addr] <= wr_data;
        palette_read <= palette[rd_addr];
    end

    assign palcolor = {palette_read[4:3], palette_read[7:6], palette_read[1:0]};

    // Entry layout is RRRGGGBB.
    always_comb
    begin
        pal_color.red = chan_compress(palette_read[7:5]);
        pal_color.grn = chan_compress(palette_read[4:2]);
        pal_color.blu = chan_compress({1'b0, palette_read[1:0]});
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            color <= '0;
        else if (blank)
            color <= '0;
        else
            color <= pal_color;
    end

    // Raster blanking must reach the output dark after the two-clock colour latency.
    a_blank_dark: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raster.hblank || raster.vblank) |-> ##2 (color == '0)
    );

endmodule

// File: rtl/video_timing.sv
`timescale 1ns/1ps
`include "video_settings.svh"

module video_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output raster_t raster
);

    localparam int CW = `VID_CNT_WIDTH;

    localparam logic [CW-1:0] H_LAST        = CW'(`VID_H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST        = CW'(`VID_V_TOTAL - 1);
    localparam logic [CW-1:0] H_PIX_START   = CW'(`VID_H_PIX_START);
    localparam logic [CW-1:0] H_PIX_END     = CW'(`VID_H_PIX_END);
    localparam logic [CW-1:0] V_PIX_START   = CW'(`VID_V_PIX_START);
    localparam logic [CW-1:0] V_PIX_END     = CW'(`VID_V_PIX_END);
    localparam logic [CW-1:0] H_BLANK_START = CW'(`VID_H_BLANK_START);
    localparam logic [CW-1:0] H_BLANK_END   = CW'(`VID_H_BLANK_END);
    localparam logic [CW-1:0] V_BLANK_START = CW'(`VID_V_BLANK_START);
    localparam logic [CW-1:0] V_BLANK_END   = CW'(`VID_V_BLANK_END);
    localparam logic [CW-1:0] H_SYNC_START  = CW'(`VID_H_SYNC_START);
    localparam logic [CW-1:0] V_SYNC_START  = CW'(`VID_V_SYNC_START);
    localparam logic [CW-1:0] V_SYNC_END    = CW'(`VID_V_SYNC_END);

    localparam int BS_W = (`VID_BORDER_SYNC_PERIOD > 1) ? $clog2(`VID_BORDER_SYNC_PERIOD) : 1;
    localparam logic [BS_W-1:0] BS_LAST = BS_W'(`VID_BORDER_SYNC_PERIOD - 1);

    logic [CW-1:0]   hcnt;
    logic [CW-1:0]   vcnt;
    logic [BS_W-1:0] bs_cnt;
    logic            line_end;
    raster_t         raster_d;

    assign line_end = (hcnt == H_LAST);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hcnt <= '0;
            vcnt <= '0;
        end
        else if (line_end)
        begin
            hcnt <= '0;
            if (vcnt == V_LAST)
                vcnt <= '0;
            else
                vcnt <= vcnt + 1'b1;
        end
        else
        begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // Restarts with every line so strobes keep their phase to the line start.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bs_cnt <= '0;
        else if (line_end || bs_cnt == BS_LAST)
            bs_cnt <= '0;
        else
            bs_cnt <= bs_cnt + 1'b1;
    end

    always_comb
    begin
        raster_d.hpix        = (hcnt >= H_PIX_START) && (hcnt < H_PIX_END);
        raster_d.vpix        = (vcnt >= V_PIX_START) && (vcnt < V_PIX_END);
        raster_d.hblank      = (hcnt >= H_BLANK_START) && (hcnt < H_BLANK_END);
        raster_d.vblank      = (vcnt >= V_BLANK_START) && (vcnt < V_BLANK_END);
        raster_d.hsync_start = (hcnt == H_SYNC_START);
        raster_d.vsync       = (vcnt >= V_SYNC_START) && (vcnt < V_SYNC_END);
        raster_d.border_sync = (bs_cnt == '0);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            raster <= '0;
        else
            raster <= raster_d;
    end

    // Line start must be a single pulse.
    a_hsync_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        raster.hsync_start |=> !raster.hsync_start
    );

    // Paper window and horizontal blanking are disjoint.
    a_hpix_blank: assert property (
        @(posedge clk) disable iff (!rst_n)
        raster.hblank |-> !raster.hpix
    );

endmodule

// File: common/video_pkg.sv
package video_pkg;

    typedef struct packed {
        logic hpix;         // Horizontal paper window.
        logic vpix;         // Vertical paper window.
        logic hblank;
        logic vblank;
        logic hsync_start;  // Single-clock line start pulse.
        logic vsync;
        logic border_sync;  // Border resync strobe.
    } raster_t;

    typedef struct packed {
        logic [3:0] pixels;     // Classic colour index.
        logic [1:0] up_palsel;
        logic [2:0] up_ink;
        logic [2:0] up_paper;
        logic       up_pixel;   // Selects ink when set.
    } pixel_t;

    typedef struct packed {
        logic       atm_palwr;   // Classic write strobe.
        logic [5:0] atm_paldata;
        logic       up_palwr;    // Extended write strobe.
        logic [5:0] up_paladdr;
        logic [7:0] up_paldata;
    } palwr_t;

    typedef struct packed {
        logic [1:0] grn;
        logic [1:0] red;
        logic [1:0] blu;
    } vid_color_t;

    // Maps a stored 3-bit channel onto the 2-bit DAC level.
    function automatic logic [1:0] chan_compress(input logic [2:0] chan);
        logic [1:0] level;
        case (chan)
            3'd0: level = 2'd0;
            3'd1: level = 2'd1;
            3'd2: level = 2'd3;
            3'd3: level = 2'd2;
            3'd4: level = 2'd0;
            3'd5: level = 2'd2;
            3'd6: level = 2'd3;
            3'd7: level = 2'd1;
            default: level = 2'd0;
        endcase
        return level;
    endfunction

endpackage

// File: common/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Raster counter width, wide enough for a full-size frame.
`define VID_CNT_WIDTH           10

`define VID_H_TOTAL             64  // Clocks per line.
`define VID_V_TOTAL             48  // Lines per frame.

// Windows are half-open, [start, end).
`define VID_H_PIX_START         12
`define VID_H_PIX_END           44
`define VID_V_PIX_START         8
`define VID_V_PIX_END           32

`define VID_H_BLANK_START       52
`define VID_H_BLANK_END         62
`define VID_V_BLANK_START       40
`define VID_V_BLANK_END         44

`define VID_H_SYNC_START        54  // One-clock pulse at this count.
`define VID_V_SYNC_START        41
`define VID_V_SYNC_END          43

`define VID_BORDER_SYNC_PERIOD  8   // Clocks between border resync strobes.

`define VID_PAL_LATENCY         1   // Palette read register stages.

`endif
